// File: addr_data.f
design/vera_regs_pkg.sv
design/vram_bus_pkg.sv
design/vram_addr_port.sv
design/reg_access_decoder.sv
design/vram_bus_sequencer.sv
design/addr_data.sv
bench/addr_data_checker.sv
bench/tb_addr_data.sv

// File: Makefile
# Verilator flow for the address and data block testbench

VERILATOR   ?= verilator
TOP         ?= tb_addr_data
FILELIST    ?= addr_data.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
FAIL_MSG    ?= TB FAILED
LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_addr_data.sv
// Testbench for the address and data block, drives host accesses and models VRAM reads
`timescale 1ns/1ps

module tb_addr_data;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_DIRECTED = 24;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_ACCESSES = NUM_DIRECTED + NUM_RANDOM;
    // Five cycles per access, plus reset and some slack
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_ACCESSES * 5 + 50) * CLK_PERIOD;

    logic                       clk;
    logic                       reset;
    logic                       do_read;
    logic                       do_write;
    vera_regs_pkg::reg_addr_t   access_addr;
    vram_bus_pkg::vram_byte_t   write_data;
    vram_bus_pkg::vram_byte_t   vram_rddata = 8'h00;
    logic                       vram_addr_select;
    vera_regs_pkg::dc_sel_t     dc_select;
    vram_bus_pkg::vram_addr_t   vram_addr_0;
    vram_bus_pkg::vram_addr_t   vram_addr_1;
    vram_bus_pkg::incr_code_t   vram_addr_incr_0;
    vram_bus_pkg::incr_code_t   vram_addr_incr_1;
    logic                       vram_addr_decr_0;
    logic                       vram_addr_decr_1;
    vram_bus_pkg::vram_byte_t   vram_data0;
    vram_bus_pkg::vram_byte_t   vram_data1;
    vram_bus_pkg::vram_addr_t   ib_addr;
    vram_bus_pkg::vram_byte_t   ib_wrdata;
    logic                       ib_write;
    logic                       ib_do_access;
    vera_regs_pkg::addr1_mode_t fx_addr1_mode;
    int                         error_count;
    int                         check_count;

    logic [31:0] lfsr_state = 32'h7636_22c9;
    logic [7:0]  vram_mem [65536];
    int          access_count = 0;

    addr_data dut_i (.*);

    addr_data_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // VRAM model
    ////////////////////

    initial begin
        for (int i = 0; i < 65536; i++) begin
            vram_mem[i] = i[7:0] ^ i[15:8];
        end
    end

    // Answers a read pulse on the next edge and holds the byte
    always @(posedge clk) begin
        if (ib_do_access && !ib_write) begin
            vram_rddata <= vram_mem[ib_addr[15:0]];
        end
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        take_bits = val;
    endfunction

    // One host access, then four idle cycles
    task automatic host_access(input logic wr, input vera_regs_pkg::reg_addr_t offset,
                               input logic [7:0] data, input logic sel,
                               input vera_regs_pkg::dc_sel_t dc);
        do_write         = wr;
        do_read          = !wr;
        access_addr      = offset;
        write_data       = data;
        vram_addr_select = sel;
        dc_select        = dc;
        @(negedge clk);
        do_write = 1'b0;
        do_read  = 1'b0;
        repeat (4) @(negedge clk);
        access_count++;
    endtask

    task automatic run_directed();
        // Port 0 at 0x01234, stride 1
        host_access(1'b1, vera_regs_pkg::ADDR_L, 8'h34, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::ADDR_M, 8'h12, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::ADDR_H, 8'h10, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::DATA0, 8'hA5, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::DATA0, 8'h5A, 1'b0, 6'd0);
        host_access(1'b0, vera_regs_pkg::DATA0, 8'h00, 1'b0, 6'd0);
        // Port 1 near the top, stride 16 wraps to zero
        host_access(1'b1, vera_regs_pkg::ADDR_L, 8'hF0, 1'b1, 6'd0);
        host_access(1'b1, vera_regs_pkg::ADDR_M, 8'hFF, 1'b1, 6'd0);
        host_access(1'b1, vera_regs_pkg::ADDR_H, 8'h51, 1'b1, 6'd0);
        host_access(1'b1, vera_regs_pkg::DATA1, 8'h11, 1'b0, 6'd0);
        host_access(1'b0, vera_regs_pkg::DATA1, 8'h00, 1'b0, 6'd0);
        // Port 0 decrements by 640 below zero
        host_access(1'b1, vera_regs_pkg::ADDR_L, 8'h10, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::ADDR_M, 8'h00, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::ADDR_H, 8'hF8, 1'b0, 6'd0);
        host_access(1'b0, vera_regs_pkg::DATA0, 8'h00, 1'b0, 6'd0);
        // Mode write with the wrong composer select is ignored
        host_access(1'b1, vera_regs_pkg::FX_CTRL, 8'h01, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::DATA1, 8'h22, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::FX_CTRL, 8'h02, 1'b0, vera_regs_pkg::DC_SEL_FX);
        host_access(1'b1, vera_regs_pkg::DATA1, 8'h77, 1'b0, 6'd0);
        host_access(1'b0, vera_regs_pkg::DATA1, 8'h00, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::DATA0, 8'h33, 1'b0, 6'd0);
        host_access(1'b1, vera_regs_pkg::ADDR_L, 8'h80, 1'b1, 6'd0);
        host_access(1'b1, vera_regs_pkg::FX_CTRL, 8'h00, 1'b0, vera_regs_pkg::DC_SEL_FX);
        host_access(1'b0, vera_regs_pkg::DATA1, 8'h00, 1'b0, 6'd0);
    endtask

    task automatic run_random();
        logic [31:0]              pick;
        logic [31:0]              bits;
        logic                     wr;
        logic                     sel;
        logic [7:0]               data;
        vera_regs_pkg::dc_sel_t   dc;
        vera_regs_pkg::reg_addr_t offset;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            pick = take_bits(3);
            bits = take_bits(2);
            wr   = (bits[1:0] != 2'b00);
            bits = take_bits(1);
            sel  = bits[0];
            bits = take_bits(8);
            data = bits[7:0];
            bits = take_bits(1);
            if (bits[0]) begin
                dc = vera_regs_pkg::DC_SEL_FX;
            end else begin
                bits = take_bits(6);
                dc   = bits[5:0];
            end
            case (pick[2:0])
                3'd0: offset = vera_regs_pkg::ADDR_L;
                3'd1: offset = vera_regs_pkg::ADDR_M;
                3'd2: offset = vera_regs_pkg::ADDR_H;
                3'd3, 3'd4: offset = vera_regs_pkg::DATA0;
                3'd5, 3'd6: offset = vera_regs_pkg::DATA1;
                default: offset = vera_regs_pkg::FX_CTRL;
            endcase
            host_access(wr, offset, data, sel, dc);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        reset            = 1'b1;
        do_read          = 1'b0;
        do_write         = 1'b0;
        access_addr      = '0;
        write_data       = '0;
        vram_addr_select = 1'b0;
        dc_select        = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        run_directed();
        run_random();
        repeat (8) @(negedge clk);
        $display("Closing report: %0d accesses, %0d checks, %0d errors",
                 access_count, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with %0d accesses done",
                 TIMEOUT_NS, access_count);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: bench/addr_data_checker.sv
// Reference model of both address ports and the internal bus that the testbench attaches to the DUT ports
`timescale 1ns/1ps

module addr_data_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       do_read,
    input  logic                       do_write,
    input  vera_regs_pkg::reg_addr_t   access_addr,
    input  vram_bus_pkg::vram_byte_t   write_data,
    input  logic                       vram_addr_select,
    input  vera_regs_pkg::dc_sel_t     dc_select,
    input  vram_bus_pkg::vram_addr_t   vram_addr_0,
    input  vram_bus_pkg::vram_addr_t   vram_addr_1,
    input  vram_bus_pkg::incr_code_t   vram_addr_incr_0,
    input  vram_bus_pkg::incr_code_t   vram_addr_incr_1,
    input  logic                       vram_addr_decr_0,
    input  logic                       vram_addr_decr_1,
    input  vram_bus_pkg::vram_byte_t   vram_data0,
    input  vram_bus_pkg::vram_byte_t   vram_data1,
    input  vram_bus_pkg::vram_addr_t   ib_addr,
    input  vram_bus_pkg::vram_byte_t   ib_wrdata,
    input  logic                       ib_write,
    input  logic                       ib_do_access,
    input  vera_regs_pkg::addr1_mode_t fx_addr1_mode,
    output int                         error_count,
    output int                         check_count
);

    logic [16:0] m_addr [2];
    logic [3:0]  m_incr [2];
    logic        m_decr [2];
    logic [7:0]  m_data [2];
    logic [1:0]  m_mode;

    // Bus pulse expected after the latest edge
    logic        exp_valid;
    logic        exp_write;
    logic [16:0] exp_addr;
    logic [7:0]  exp_wrdata;

    logic        fetch_wait;
    logic        fetch_port_m;
    logic [1:0]  cap_wait;
    logic        cap_port;
    logic [7:0]  cap_value;
    logic        sel;
    logic        is_data;
    int          errors = 0;
    int          checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    ////////////////////
    // Reference functions
    ////////////////////

    function automatic logic [16:0] stride_of(input logic [3:0] code);
        if (code == 4'd0) begin
            stride_of = 17'd0;
        end else if (code <= 4'd10) begin
            stride_of = 17'd1 << (code - 4'd1);
        end else begin
            stride_of = 17'd40 << (code - 4'd11);
        end
    endfunction

    function automatic logic [16:0] ref_next_addr(input logic [16:0] addr,
            input logic [3:0] incr, input logic decr, input logic [4:0] offset,
            input logic [7:0] wdata, input logic is_step);
        if (is_step) begin
            // 17-bit arithmetic wraps on its own
            ref_next_addr = decr ? addr - stride_of(incr) : addr + stride_of(incr);
        end else begin
            case (offset)
                vera_regs_pkg::ADDR_L: ref_next_addr = {addr[16:8], wdata};
                vera_regs_pkg::ADDR_M: ref_next_addr = {addr[16], wdata, addr[7:0]};
                vera_regs_pkg::ADDR_H:
                    ref_next_addr = {wdata[vera_regs_pkg::BANK_BIT], addr[15:0]};
                default: ref_next_addr = addr;
            endcase
        end
    endfunction

    function automatic logic [7:0] mem_byte(input logic [16:0] addr);
        mem_byte = addr[7:0] ^ addr[15:8];
    endfunction

    ////////////////////
    // Model update
    ////////////////////

    always @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < 2; p++) begin
                m_addr[p] = '0;
                m_incr[p] = '0;
                m_decr[p] = 1'b0;
                m_data[p] = '0;
            end
            m_mode     = '0;
            exp_valid  = 1'b0;
            fetch_wait = 1'b0;
            cap_wait   = '0;
        end else begin
            exp_valid = 1'b0;
            // Captured byte lands two edges after its read pulse
            if (cap_wait == 2'd1) begin
                m_data[cap_port] = cap_value;
            end
            if (cap_wait != 2'd0) begin
                cap_wait = cap_wait - 2'd1;
            end
            if (fetch_wait) begin
                exp_valid  = 1'b1;
                exp_write  = 1'b0;
                exp_addr   = m_addr[fetch_port_m];
                cap_port   = fetch_port_m;
                cap_value  = mem_byte(m_addr[fetch_port_m]);
                cap_wait   = 2'd2;
                fetch_wait = 1'b0;
            end

            sel     = vram_addr_select;
            is_data = (do_read || do_write) && (access_addr == vera_regs_pkg::DATA0 ||
                                                access_addr == vera_regs_pkg::DATA1);
            if (is_data) begin
                sel = (access_addr == vera_regs_pkg::DATA1);
                if (do_write) begin
                    exp_valid  = 1'b1;
                    exp_write  = 1'b1;
                    exp_addr   = m_addr[sel];
                    exp_wrdata = write_data;
                end
                // Port 1 freezes outside the normal mode
                if (!sel || m_mode == vera_regs_pkg::MODE_NORMAL) begin
                    m_addr[sel]  = ref_next_addr(m_addr[sel], m_incr[sel], m_decr[sel],
                                                 access_addr, write_data, 1'b1);
                    fetch_wait   = 1'b1;
                    fetch_port_m = sel;
                end
            end else if (do_write && (access_addr == vera_regs_pkg::ADDR_L ||
                                      access_addr == vera_regs_pkg::ADDR_M ||
                                      access_addr == vera_regs_pkg::ADDR_H)) begin
                m_addr[sel] = ref_next_addr(m_addr[sel], m_incr[sel], m_decr[sel],
                                            access_addr, write_data, 1'b0);
                if (access_addr == vera_regs_pkg::ADDR_H) begin
                    m_incr[sel] = write_data[7:4];
                    m_decr[sel] = write_data[3];
                end
                fetch_wait   = 1'b1;
                fetch_port_m = sel;
            end else if (do_write && access_addr == vera_regs_pkg::FX_CTRL &&
                         dc_select == vera_regs_pkg::DC_SEL_FX) begin
                m_mode = write_data[1:0];
            end
        end
    end

    ////////////////////
    // Comparison
    ////////////////////

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] t=%0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin
        compare_field("vram_addr_0", 32'(vram_addr_0), 32'(m_addr[0]));
        compare_field("vram_addr_1", 32'(vram_addr_1), 32'(m_addr[1]));
        compare_field("vram_addr_incr_0", 32'(vram_addr_incr_0), 32'(m_incr[0]));
        compare_field("vram_addr_incr_1", 32'(vram_addr_incr_1), 32'(m_incr[1]));
        compare_field("vram_addr_decr_0", 32'(vram_addr_decr_0), 32'(m_decr[0]));
        compare_field("vram_addr_decr_1", 32'(vram_addr_decr_1), 32'(m_decr[1]));
        compare_field("vram_data0", 32'(vram_data0), 32'(m_data[0]));
        compare_field("vram_data1", 32'(vram_data1), 32'(m_data[1]));
        compare_field("fx_addr1_mode", 32'(fx_addr1_mode), 32'(m_mode));
        compare_field("ib_do_access", 32'(ib_do_access), 32'(exp_valid));
        if (reset) begin
            // Idle bus fields are zero under reset
            compare_field("ib_addr", 32'(ib_addr), 32'd0);
            compare_field("ib_wrdata", 32'(ib_wrdata), 32'd0);
            compare_field("ib_write", 32'(ib_write), 32'd0);
        end else if (exp_valid && ib_do_access) begin
            compare_field("ib_write", 32'(ib_write), 32'(exp_write));
            compare_field("ib_addr", 32'(ib_addr), 32'(exp_addr));
            if (exp_write) begin
                compare_field("ib_wrdata", 32'(ib_wrdata), 32'(exp_wrdata));
            end
        end
    end

endmodule

// File: design/addr_data.sv
// Top of the dual address-port block, connects decoder, both pointers and the bus sequencer
`timescale 1ns/1ps

module addr_data (
    input  logic                       reset,
    input  logic                       clk,
    input  logic                       do_read,
    input  logic                       do_write,
    input  vera_regs_pkg::reg_addr_t   access_addr,
    input  vram_bus_pkg::vram_byte_t   write_data,
    input  vram_bus_pkg::vram_byte_t   vram_rddata,
    input  logic                       vram_addr_select,
    input  vera_regs_pkg::dc_sel_t     dc_select,
    output vram_bus_pkg::vram_addr_t   vram_addr_0,
    output vram_bus_pkg::vram_addr_t   vram_addr_1,
    output vram_bus_pkg::incr_code_t   vram_addr_incr_0,
    output vram_bus_pkg::incr_code_t   vram_addr_incr_1,
    output logic                       vram_addr_decr_0,
    output logic                       vram_addr_decr_1,
    output vram_bus_pkg::vram_byte_t   vram_data0,
    output vram_bus_pkg::vram_byte_t   vram_data1,
    output vram_bus_pkg::vram_addr_t   ib_addr,
    output vram_bus_pkg::vram_byte_t   ib_wrdata,
    output logic                       ib_write,
    output logic                       ib_do_access,
    output vera_regs_pkg::addr1_mode_t fx_addr1_mode
);

    logic set_low_0, set_mid_0, set_high_0, step_0;
    logic set_low_1, set_mid_1, set_high_1, step_1;
    logic data_write, data_port, fetch_req, fetch_port;

    reg_access_decoder decoder_i (
        .clk(clk), .reset(reset), .do_read(do_read), .do_write(do_write),
        .access_addr(access_addr), .write_data(write_data),
        .vram_addr_select(vram_addr_select), .dc_select(dc_select),
        .set_low_0(set_low_0), .set_mid_0(set_mid_0), .set_high_0(set_high_0),
        .step_0(step_0), .set_low_1(set_low_1), .set_mid_1(set_mid_1),
        .set_high_1(set_high_1), .step_1(step_1), .data_write(data_write),
        .data_port(data_port), .fetch_req(fetch_req), .fetch_port(fetch_port),
        .fx_addr1_mode(fx_addr1_mode)
    );

    vram_addr_port port_0_i (
        .clk(clk), .reset(reset), .set_low(set_low_0), .set_mid(set_mid_0),
        .set_high(set_high_0), .step(step_0), .write_data(write_data),
        .addr(vram_addr_0), .incr(vram_addr_incr_0), .decr(vram_addr_decr_0)
    );

    vram_addr_port port_1_i (
        .clk(clk), .reset(reset), .set_low(set_low_1), .set_mid(set_mid_1),
        .set_high(set_high_1), .step(step_1), .write_data(write_data),
        .addr(vram_addr_1), .incr(vram_addr_incr_1), .decr(vram_addr_decr_1)
    );

    vram_bus_sequencer sequencer_i (
        .clk(clk), .reset(reset), .data_write(data_write), .data_port(data_port),
        .write_data(write_data), .fetch_req(fetch_req), .fetch_port(fetch_port),
        .addr_0(vram_addr_0), .addr_1(vram_addr_1), .vram_rddata(vram_rddata),
        .ib_addr(ib_addr), .ib_wrdata(ib_wrdata), .ib_write(ib_write),
        .ib_do_access(ib_do_access), .vram_data0(vram_data0), .vram_data1(vram_data1)
    );

endmodule

// File: design/vram_bus_sequencer.sv
// Issues VRAM writes and fetch-ahead reads on the internal bus and captures read data
`timescale 1ns/1ps

module vram_bus_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     data_write,
    input  logic                     data_port,
    input  vram_bus_pkg::vram_byte_t write_data,
    input  logic                     fetch_req,
    input  logic                     fetch_port,
    input  vram_bus_pkg::vram_addr_t addr_0,
    input  vram_bus_pkg::vram_addr_t addr_1,
    input  vram_bus_pkg::vram_byte_t vram_rddata,
    output vram_bus_pkg::vram_addr_t ib_addr,
    output vram_bus_pkg::vram_byte_t ib_wrdata,
    output logic                     ib_write,
    output logic                     ib_do_access,
    output vram_bus_pkg::vram_byte_t vram_data0,
    output vram_bus_pkg::vram_byte_t vram_data1
);

    // Fetch waits one cycle so the pointer has already stepped
    logic fetch_pending_r;
    logic fetch_port_r;

    // Read pipeline, one stage per bus cycle
    logic ib_port_r;
    logic save_result_r;
    logic save_port_r;

    ////////////////////
    // Bus requests
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ib_addr         <= '0;
            ib_wrdata       <= '0;
            ib_write        <= 1'b0;
            ib_do_access    <= 1'b0;
            ib_port_r       <= 1'b0;
            fetch_pending_r <= 1'b0;
            fetch_port_r    <= 1'b0;
        end else begin
            ib_do_access <= 1'b0;
            if (fetch_pending_r) begin
                ib_addr      <= fetch_port_r ? addr_1 : addr_0;
                ib_write     <= 1'b0;
                ib_do_access <= 1'b1;
                ib_port_r    <= fetch_port_r;
            end else if (data_write) begin
                // Pointer is still the pre-step value in this cycle
                ib_addr      <= data_port ? addr_1 : addr_0;
                ib_wrdata    <= write_data;
                ib_write     <= 1'b1;
                ib_do_access <= 1'b1;
            end

            fetch_pending_r <= fetch_req;
            if (fetch_req) begin
                fetch_port_r <= fetch_port;
            end
        end
    end

    ////////////////////
    // Read capture
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            save_result_r <= 1'b0;
            save_port_r   <= 1'b0;
            vram_data0    <= '0;
            vram_data1    <= '0;
        end else begin
            save_result_r <= ib_do_access && !ib_write;
            save_port_r   <= ib_port_r;
            if (save_result_r && !save_port_r) begin
                vram_data0 <= vram_rddata;
            end
            if (save_result_r && save_port_r) begin
                vram_data1 <= vram_rddata;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Host spacing keeps writes apart on the bus
    assert property (@(posedge clk) disable iff (reset)
        (ib_do_access && ib_write) |=> !(ib_do_access && ib_write))
    else $error("bus sequencer: back-to-back write pulses");

    // A write arriving under a pending fetch would be dropped
    assert property (@(posedge clk) disable iff (reset)
        !(data_write && fetch_pending_r))
    else $error("bus sequencer: data write collides with pending fetch");

endmodule

// File: design/reg_access_decoder.sv
// Decodes host register accesses into address port strobes and bus requests, holds FX_CTRL mode
`timescale 1ns/1ps

module reg_access_decoder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       do_read,
    input  logic                       do_write,
    input  vera_regs_pkg::reg_addr_t   access_addr,
    input  vram_bus_pkg::vram_byte_t   write_data,
    input  logic                       vram_addr_select,
    input  vera_regs_pkg::dc_sel_t     dc_select,
    output logic                       set_low_0,
    output logic                       set_mid_0,
    output logic                       set_high_0,
    output logic                       step_0,
    output logic                       set_low_1,
    output logic                       set_mid_1,
    output logic                       set_high_1,
    output logic                       step_1,
    output logic                       data_write,
    output logic                       data_port,
    output logic                       fetch_req,
    output logic                       fetch_port,
    output vera_regs_pkg::addr1_mode_t fx_addr1_mode
);

    logic data0_access;
    logic data1_access;
    logic change_0;
    logic change_1;

    vera_regs_pkg::addr1_mode_t mode_r;

    ////////////////////
    // Address loads
    ////////////////////

    assign set_low_0  = do_write && access_addr == vera_regs_pkg::ADDR_L && !vram_addr_select;
    assign set_mid_0  = do_write && access_addr == vera_regs_pkg::ADDR_M && !vram_addr_select;
    assign set_high_0 = do_write && access_addr == vera_regs_pkg::ADDR_H && !vram_addr_select;
    assign set_low_1  = do_write && access_addr == vera_regs_pkg::ADDR_L && vram_addr_select;
    assign set_mid_1  = do_write && access_addr == vera_regs_pkg::ADDR_M && vram_addr_select;
    assign set_high_1 = do_write && access_addr == vera_regs_pkg::ADDR_H && vram_addr_select;

    ////////////////////
    // Data accesses
    ////////////////////

    assign data0_access = (do_read || do_write) && access_addr == vera_regs_pkg::DATA0;
    assign data1_access = (do_read || do_write) && access_addr == vera_regs_pkg::DATA1;

    // Port 1 only steps in normal mode
    assign step_0 = data0_access;
    assign step_1 = data1_access && mode_r == vera_regs_pkg::MODE_NORMAL;

    assign data_write = do_write && (data0_access || data1_access);
    assign data_port  = data1_access;

    // Any pointer change asks for a fetch-ahead, port 0 first
    assign change_0   = set_low_0 || set_mid_0 || set_high_0 || step_0;
    assign change_1   = set_low_1 || set_mid_1 || set_high_1 || step_1;
    assign fetch_req  = change_0 || change_1;
    assign fetch_port = !change_0;

    ////////////////////
    // FX_CTRL mode
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode_r <= vera_regs_pkg::MODE_NORMAL;
        end else if (do_write && access_addr == vera_regs_pkg::FX_CTRL &&
                     dc_select == vera_regs_pkg::DC_SEL_FX) begin
            mode_r <= write_data[vera_regs_pkg::MODE_W-1:0];
        end
    end

    assign fx_addr1_mode = mode_r;

endmodule

// File: design/vram_addr_port.sv
// One VRAM address pointer with stride code and direction, loaded bytewise by the host
`timescale 1ns/1ps

module vram_addr_port (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     set_low,
    input  logic                     set_mid,
    input  logic                     set_high,
    input  logic                     step,
    input  vram_bus_pkg::vram_byte_t write_data,
    output vram_bus_pkg::vram_addr_t addr,
    output vram_bus_pkg::incr_code_t incr,
    output logic                     decr
);

    localparam int ADDR_W = vram_bus_pkg::VRAM_ADDR_W;
    localparam int BYTE_W = vram_bus_pkg::VRAM_DATA_W;
    localparam int STEP_W = vram_bus_pkg::STEP_W;

    vram_bus_pkg::step_t      table_step;
    vram_bus_pkg::step_t      signed_step;
    vram_bus_pkg::vram_addr_t step_addr;

    ////////////////////
    // Stepping adder
    ////////////////////

    assign table_step  = vram_bus_pkg::STRIDE_TABLE[incr];
    assign signed_step = decr ? -table_step : table_step;

    // Sign extend the step so a decrement wraps modulo 2^17
    assign step_addr = addr + {{(ADDR_W - STEP_W){signed_step[STEP_W-1]}}, signed_step};

    ////////////////////
    // Pointer registers
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr <= '0;
            incr <= '0;
            decr <= 1'b0;
        end else begin
            if (step) begin
                addr <= step_addr;
            end else begin
                if (set_low) begin
                    addr[BYTE_W-1:0] <= write_data;
                end
                if (set_mid) begin
                    addr[2*BYTE_W-1:BYTE_W] <= write_data;
                end
                if (set_high) begin
                    // Bank bit is address bit 16
                    addr[ADDR_W-1] <= write_data[vera_regs_pkg::BANK_BIT];
                end
            end
            if (set_high) begin
                incr <= write_data[vera_regs_pkg::INCR_LSB +: vram_bus_pkg::INCR_CODE_W];
                decr <= write_data[vera_regs_pkg::DECR_BIT];
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // The decoder serves one host access per cycle, so a data step and
    // an address load never meet on the same port
    assert property (@(posedge clk) disable iff (reset)
        step |-> !(set_low || set_mid || set_high))
    else $error("address port: step and set strobe in the same cycle");

endmodule

// File: design/vram_bus_pkg.sv
// VRAM side types and the address stride table shared by the address ports
package vram_bus_pkg;

    localparam int VRAM_ADDR_W = 17;
    localparam int VRAM_DATA_W = 8;
    localparam int INCR_CODE_W = 4;
    localparam int STEP_W      = 11;
    localparam int NUM_STRIDES = 2 ** INCR_CODE_W;

    typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
    typedef logic [VRAM_DATA_W-1:0] vram_byte_t;
    typedef logic [INCR_CODE_W-1:0] incr_code_t;
    typedef logic signed [STEP_W-1:0] step_t;

    ////////////////////
    // Stride table
    ////////////////////

    // Codes 0..10 are powers of two (code 0 means no step),
    // codes 11..15 are multiples of 40 for tile and bitmap rows
    localparam step_t STRIDE_TABLE [NUM_STRIDES] = '{
        11'sd0,   11'sd1,   11'sd2,   11'sd4,
        11'sd8,   11'sd16,  11'sd32,  11'sd64,
        11'sd128, 11'sd256, 11'sd512, 11'sd40,
        11'sd80,  11'sd160, 11'sd320, 11'sd640
    };

endpackage

// File: design/vera_regs_pkg.sv
// Host register window of the address and data block: offsets, ADDR_H fields, address-1 modes
package vera_regs_pkg;

    ////////////////////
    // Register offsets
    ////////////////////

    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t ADDR_L  = 5'h00;
    localparam reg_addr_t ADDR_M  = 5'h01;
    localparam reg_addr_t ADDR_H  = 5'h02;
    localparam reg_addr_t DATA0   = 5'h03;
    localparam reg_addr_t DATA1   = 5'h04;
    localparam reg_addr_t FX_CTRL = 5'h09;

    // Display-composer select, picks the bank behind offsets 09 and up
    localparam int DC_SEL_W = 6;
    typedef logic [DC_SEL_W-1:0] dc_sel_t;

    localparam dc_sel_t DC_SEL_FX = 6'd2;

    // Address-1 mode held in FX_CTRL
    localparam int MODE_W = 2;
    typedef logic [MODE_W-1:0] addr1_mode_t;

    localparam addr1_mode_t MODE_NORMAL = 2'd0;

    ////////////////////
    // ADDR_H fields
    ////////////////////

    localparam int INCR_LSB = 4;
    localparam int DECR_BIT = 3;
    localparam int BANK_BIT = 0;

endpackage
